// File: hcache_pkg.sv
// Harvard cache shared constants
package hcache_pkg;

   // Byte address width.
   localparam int AWIDTH = 14;

   // RAM size in bytes.
   localparam int RAM_SIZE = 16384;

   // Number of 32-bit words held in RAM.
   localparam int RAM_WORDS = RAM_SIZE / 4;

   // Cache index widths, 64 lines each.
   localparam int ICWIDTH = 6;
   localparam int DCWIDTH = 6;

   // Tag is what remains above the index and byte offset.
   localparam int ITAG_W = AWIDTH - 2 - ICWIDTH;
   localparam int DTAG_W = AWIDTH - 2 - DCWIDTH;

   // Stall counter width.
   localparam int CNT_W = 16;

endpackage

// File: dpram32.sv
// Dual-port 32-bit RAM
`timescale 1ns/1ps

module dpram32 (
   input  logic                          wb_clk_i,

   input  logic [hcache_pkg::AWIDTH-1:0] adr1_i,
   input  logic [31:0]                   dat1_i,
   input  logic                          we1_i,
   input  logic                          en1_i,
   input  logic [3:0]                    sel1_i,
   output logic [31:0]                   dat1_o,

   input  logic [hcache_pkg::AWIDTH-1:0] adr2_i,
   input  logic [31:0]                   dat2_i,
   input  logic                          we2_i,
   input  logic                          en2_i,
   input  logic [3:0]                    sel2_i,
   output logic [31:0]                   dat2_o
);

   logic [31:0] mem [hcache_pkg::RAM_WORDS];

   logic [hcache_pkg::AWIDTH-3:0] wadr1;
   logic [hcache_pkg::AWIDTH-3:0] wadr2;

   assign wadr1 = adr1_i[hcache_pkg::AWIDTH-1:2]; // Word index.
   assign wadr2 = adr2_i[hcache_pkg::AWIDTH-1:2];

   // Both ports share one process since they share the array.
   always_ff @(posedge wb_clk_i) begin
      if (en1_i) begin
         if (we1_i) begin
            for (int b = 0; b < 4; b++)
               if (sel1_i[b])
                  mem[wadr1][8*b +: 8] <= dat1_i[8*b +: 8];
         end else begin
            dat1_o <= mem[wadr1];
         end
      end

      if (en2_i) begin
         if (we2_i) begin
            for (int b = 0; b < 4; b++)
               if (sel2_i[b])
                  mem[wadr2][8*b +: 8] <= dat2_i[8*b +: 8];
         end else begin
            dat2_o <= mem[wadr2];
         end
      end
   end

endmodule

// File: icache.sv
// Direct-mapped instruction cache
`timescale 1ns/1ps

module icache (
   input  logic                          wb_clk_i,
   input  logic                          arst_n_i,

   input  logic [hcache_pkg::AWIDTH-1:0] iwb_adr_i,
   input  logic                          iwb_stb_i,
   output logic [31:0]                   iwb_dat_o,
   output logic                          iwb_ack_o,

   input  logic                          ram_loader_done_i,

   input  logic [31:0]                   iram_dat_i,
   output logic [hcache_pkg::AWIDTH-1:0] iram_adr_o,
   output logic                          iram_en_o
);

   logic [hcache_pkg::ICWIDTH-1:0]    idx;
   logic [hcache_pkg::ITAG_W-1:0]     tag;
   logic [hcache_pkg::ITAG_W-1:0]     tags [2**hcache_pkg::ICWIDTH];
   logic [31:0]                       data [2**hcache_pkg::ICWIDTH];
   logic [2**hcache_pkg::ICWIDTH-1:0] valid;
   logic                              hit;
   logic                              miss_pend;

   assign idx = iwb_adr_i[hcache_pkg::ICWIDTH+1:2];
   assign tag = iwb_adr_i[hcache_pkg::AWIDTH-1:hcache_pkg::ICWIDTH+2];
   assign hit = valid[idx] && (tags[idx] == tag);

   // RAM is only touched on a miss, and never during the boot load.
   assign iram_adr_o = iwb_adr_i;
   assign iram_en_o  = iwb_stb_i && !hit && !miss_pend && ram_loader_done_i;

   // Hit answers now, miss answers one cycle later from RAM.
   assign iwb_ack_o = iwb_stb_i && (hit || miss_pend);
   assign iwb_dat_o = miss_pend ? iram_dat_i : data[idx];

   always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         valid     <= '0;
         miss_pend <= 1'b0;
      end else begin
         miss_pend <= iram_en_o; // Fill cycle follows the RAM read.
         if (!ram_loader_done_i)
            valid <= '0; // Contents not trusted until load done.
         else if (miss_pend)
            valid[idx] <= 1'b1;
      end
   end

   // Line fill.
   always_ff @(posedge wb_clk_i) begin
      if (miss_pend) begin
         tags[idx] <= tag;
         data[idx] <= iram_dat_i;
      end
   end

endmodule

// File: dcache.sv
// Direct-mapped write-through data cache
`timescale 1ns/1ps

module dcache (
   input  logic                          wb_clk_i,
   input  logic                          arst_n_i,

   input  logic [hcache_pkg::AWIDTH-1:0] dwb_adr_i,
   input  logic [31:0]                   dwb_dat_i,
   input  logic                          dwb_we_i,
   input  logic [3:0]                    dwb_sel_i,
   input  logic                          dwb_stb_i,
   output logic [31:0]                   dwb_dat_o,
   output logic                          dwb_ack_o,

   input  logic [31:0]                   dram_dat_i,
   output logic [hcache_pkg::AWIDTH-1:0] dram_adr_o,
   output logic [31:0]                   dram_dat_o,
   output logic                          dram_we_o,
   output logic                          dram_en_o,
   output logic [3:0]                    dram_sel_o
);

   logic [hcache_pkg::DCWIDTH-1:0]    idx;
   logic [hcache_pkg::DTAG_W-1:0]     tag;
   logic [hcache_pkg::DTAG_W-1:0]     tags [2**hcache_pkg::DCWIDTH];
   logic [31:0]                       data [2**hcache_pkg::DCWIDTH];
   logic [2**hcache_pkg::DCWIDTH-1:0] valid;
   logic                              hit;
   logic                              rd_miss;
   logic                              wr_hit;
   logic                              miss_pend;

   assign idx = dwb_adr_i[hcache_pkg::DCWIDTH+1:2];
   assign tag = dwb_adr_i[hcache_pkg::AWIDTH-1:hcache_pkg::DCWIDTH+2];
   assign hit = valid[idx] && (tags[idx] == tag);

   assign rd_miss = dwb_stb_i && !dwb_we_i && !hit && !miss_pend;
   assign wr_hit  = dwb_stb_i && dwb_we_i && hit;

   // Every write goes straight to RAM.
   assign dram_adr_o = dwb_adr_i;
   assign dram_dat_o = dwb_dat_i;
   assign dram_we_o  = dwb_stb_i && dwb_we_i;
   assign dram_en_o  = dram_we_o || rd_miss;
   assign dram_sel_o = dwb_we_i ? dwb_sel_i : 4'hF; // Reads fetch the full word.

   // Writes never wait.
   assign dwb_ack_o = dwb_stb_i && (dwb_we_i || hit || miss_pend);
   assign dwb_dat_o = miss_pend ? dram_dat_i : data[idx];

   always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         valid     <= '0;
         miss_pend <= 1'b0;
      end else begin
         miss_pend <= rd_miss;
         if (miss_pend)
            valid[idx] <= 1'b1; // Write misses never allocate.
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (miss_pend) begin
         tags[idx] <= tag;
         data[idx] <= dram_dat_i;
      end else if (wr_hit) begin
         // Merge only the selected bytes.
         for (int b = 0; b < 4; b++)
            if (dwb_sel_i[b])
               data[idx][8*b +: 8] <= dwb_dat_i[8*b +: 8];
      end
   end

endmodule

// File: perf_stall_counter.sv
// Bus stall cycle counters
`timescale 1ns/1ps

module perf_stall_counter (
   input  logic                         wb_clk_i,
   input  logic                         arst_n_i,

   input  logic                         iwb_stb_i,
   input  logic                         iwb_ack_i,
   input  logic                         dwb_stb_i,
   input  logic                         dwb_ack_i,

   output logic [hcache_pkg::CNT_W-1:0] i_stall_cnt_o,
   output logic [hcache_pkg::CNT_W-1:0] d_stall_cnt_o
);

   logic [1:0]                         stall;
   logic [1:0][hcache_pkg::CNT_W-1:0] cnt;

   // Bit 0 is the instruction bus, bit 1 the data bus.
   assign stall[0] = iwb_stb_i && !iwb_ack_i;
   assign stall[1] = dwb_stb_i && !dwb_ack_i;

   always_ff @(posedge wb_clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         cnt <= '0;
      end else begin
         for (int n = 0; n < 2; n++)
            if (stall[n] && (cnt[n] != '1))
               cnt[n] <= cnt[n] + 1'b1; // Holds at all ones.
      end
   end

   assign i_stall_cnt_o = cnt[0];
   assign d_stall_cnt_o = cnt[1];

endmodule

// File: ram_harv_cache.sv
// Harvard cached dual-port RAM
`timescale 1ns/1ps

module ram_harv_cache (
   input  logic                          wb_clk_i,
   input  logic                          arst_n_i,

   input  logic [hcache_pkg::AWIDTH-1:0] ram_loader_adr_i,
   input  logic [31:0]                   ram_loader_dat_i,
   input  logic [3:0]                    ram_loader_sel_i,
   input  logic                          ram_loader_we_i,
   input  logic                          ram_loader_stb_i,
   output logic                          ram_loader_ack_o,
   input  logic                          ram_loader_done_i,

   input  logic [hcache_pkg::AWIDTH-1:0] iwb_adr_i,
   input  logic                          iwb_stb_i,
   output logic [31:0]                   iwb_dat_o,
   output logic                          iwb_ack_o,

   input  logic [hcache_pkg::AWIDTH-1:0] dwb_adr_i,
   input  logic [31:0]                   dwb_dat_i,
   output logic [31:0]                   dwb_dat_o,
   input  logic                          dwb_we_i,
   input  logic [3:0]                    dwb_sel_i,
   input  logic                          dwb_stb_i,
   output logic                          dwb_ack_o,

   output logic [hcache_pkg::CNT_W-1:0]  i_stall_cnt_o,
   output logic [hcache_pkg::CNT_W-1:0]  d_stall_cnt_o
);

   logic [hcache_pkg::AWIDTH-1:0] iram_adr, dram_adr, p1_adr;
   logic [31:0]                   iram_dat, dram_rdat, dram_wdat;
   logic                          iram_en, dram_en, dram_we;
   logic                          p1_en, p1_we;
   logic [3:0]                    dram_sel, p1_sel;

   // Port 1 belongs to the loader until done, then to the icache.
   assign p1_adr = ram_loader_done_i ? iram_adr : ram_loader_adr_i;
   assign p1_en  = ram_loader_done_i ? iram_en : ram_loader_stb_i;
   assign p1_we  = ram_loader_done_i ? 1'b0 : ram_loader_we_i;
   assign p1_sel = ram_loader_done_i ? 4'hF : ram_loader_sel_i;

   assign ram_loader_ack_o = ram_loader_stb_i; // RAM takes a write every cycle.

   dpram32 sys_ram (
      .wb_clk_i (wb_clk_i),
      .adr1_i   (p1_adr),
      .dat1_i   (ram_loader_dat_i),
      .we1_i    (p1_we),
      .en1_i    (p1_en),
      .sel1_i   (p1_sel),
      .dat1_o   (iram_dat),
      .adr2_i   (dram_adr),
      .dat2_i   (dram_wdat),
      .we2_i    (dram_we),
      .en2_i    (dram_en),
      .sel2_i   (dram_sel),
      .dat2_o   (dram_rdat)
   );

   icache icache (
      .wb_clk_i          (wb_clk_i),
      .arst_n_i          (arst_n_i),
      .iwb_adr_i         (iwb_adr_i),
      .iwb_stb_i         (iwb_stb_i),
      .iwb_dat_o         (iwb_dat_o),
      .iwb_ack_o         (iwb_ack_o),
      .ram_loader_done_i (ram_loader_done_i),
      .iram_dat_i        (iram_dat),
      .iram_adr_o        (iram_adr),
      .iram_en_o         (iram_en)
   );

   dcache dcache (
      .wb_clk_i   (wb_clk_i),
      .arst_n_i   (arst_n_i),
      .dwb_adr_i  (dwb_adr_i),
      .dwb_dat_i  (dwb_dat_i),
      .dwb_we_i   (dwb_we_i),
      .dwb_sel_i  (dwb_sel_i),
      .dwb_stb_i  (dwb_stb_i),
      .dwb_dat_o  (dwb_dat_o),
      .dwb_ack_o  (dwb_ack_o),
      .dram_dat_i (dram_rdat),
      .dram_adr_o (dram_adr),
      .dram_dat_o (dram_wdat),
      .dram_we_o  (dram_we),
      .dram_en_o  (dram_en),
      .dram_sel_o (dram_sel)
   );

   // Performance monitoring.
   perf_stall_counter stall_cnt (
      .wb_clk_i      (wb_clk_i),
      .arst_n_i      (arst_n_i),
      .iwb_stb_i     (iwb_stb_i),
      .iwb_ack_i     (iwb_ack_o),
      .dwb_stb_i     (dwb_stb_i),
      .dwb_ack_i     (dwb_ack_o),
      .i_stall_cnt_o (i_stall_cnt_o),
      .d_stall_cnt_o (d_stall_cnt_o)
   );

endmodule

// File: ram_harv_cache_checker.sv
// Harvard cache handshake assertions
`timescale 1ns/1ps

module ram_harv_cache_checker (
   input logic wb_clk_i,
   input logic arst_n_i,
   input logic iwb_stb_i,
   input logic iwb_ack_i,
   input logic dwb_stb_i,
   input logic dwb_ack_i,
   input logic ldr_stb_i,
   input logic ldr_ack_i,
   input logic ldr_done_i,
   input logic iram_en_i,
   input logic dram_en_i,
   input logic dram_we_i
);

   iack_needs_stb: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
      iwb_ack_i |-> iwb_stb_i)
      else $error("Icache ack without a strobe.");

   dack_needs_stb: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
      dwb_ack_i |-> dwb_stb_i)
      else $error("Dcache ack without a strobe.");

   loader_ack: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
      ldr_ack_i == ldr_stb_i)
      else $error("Loader ack does not follow its strobe.");

   // RAM read on a miss is answered one cycle later.
   imiss_ack_next: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
      iram_en_i |=> iwb_ack_i)
      else $error("Icache missed read not acked in the next cycle.");

   dmiss_ack_next: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
      (dram_en_i && !dram_we_i) |=> dwb_ack_i)
      else $error("Dcache missed read not acked in the next cycle.");

   no_fetch_in_load: assert property (@(posedge wb_clk_i) disable iff (!arst_n_i)
      iram_en_i |-> ldr_done_i)
      else $error("Icache enabled port 1 during the boot load.");

endmodule

bind ram_harv_cache ram_harv_cache_checker checker_i (
   .wb_clk_i   (wb_clk_i),
   .arst_n_i   (arst_n_i),
   .iwb_stb_i  (iwb_stb_i),
   .iwb_ack_i  (iwb_ack_o),
   .dwb_stb_i  (dwb_stb_i),
   .dwb_ack_i  (dwb_ack_o),
   .ldr_stb_i  (ram_loader_stb_i),
   .ldr_ack_i  (ram_loader_ack_o),
   .ldr_done_i (ram_loader_done_i),
   .iram_en_i  (iram_en),
   .dram_en_i  (dram_en),
   .dram_we_i  (dram_we)
);

// File: tb_ram_harv_cache.sv
// Harvard cache testbench
`timescale 1ns/1ps

module tb_ram_harv_cache;

   localparam int PERIOD     = 100;
   localparam int RST_CYCLES = 4;
   localparam int SEED       = 92244;
   localparam int AW         = hcache_pkg::AWIDTH;
   localparam int ICLINES    = 2**hcache_pkg::ICWIDTH;
   localparam int DCLINES    = 2**hcache_pkg::DCWIDTH;

   localparam int N_LOAD  = 256;
   localparam int N_PART  = 32;
   localparam int N_FETCH = 64;
   localparam int N_MIX   = 96;
   localparam int N_DPRE  = 32;
   localparam int N_DWR   = 64;
   localparam int N_EVICT = 16;
   // Reset check, evict write and evict fetch add three.
   localparam int TOTAL_ACC = N_LOAD + N_PART + N_FETCH + N_MIX + N_DPRE + 2*N_DWR
                              + N_EVICT + 3;
   localparam int TIMEOUT = TOTAL_ACC * 3 * PERIOD * 2 + RST_CYCLES * PERIOD;

   // Same data index, different tags.
   localparam int EVICT_A  = 130;
   localparam int EVICT_B  = EVICT_A + DCLINES;
   localparam int NEW_WORD = 200; // Above every fetched word.

   logic                          wb_clk_i;
   logic                          arst_n_i;
   logic [AW-1:0]                 ram_loader_adr_i;
   logic [31:0]                   ram_loader_dat_i;
   logic [3:0]                    ram_loader_sel_i;
   logic                          ram_loader_we_i;
   logic                          ram_loader_stb_i;
   logic                          ram_loader_ack_o;
   logic                          ram_loader_done_i;
   logic [AW-1:0]                 iwb_adr_i;
   logic                          iwb_stb_i;
   logic [31:0]                   iwb_dat_o;
   logic                          iwb_ack_o;
   logic [AW-1:0]                 dwb_adr_i;
   logic [31:0]                   dwb_dat_i;
   logic [31:0]                   dwb_dat_o;
   logic                          dwb_we_i;
   logic [3:0]                    dwb_sel_i;
   logic                          dwb_stb_i;
   logic                          dwb_ack_o;
   logic [hcache_pkg::CNT_W-1:0]  i_stall_cnt_o;
   logic [hcache_pkg::CNT_W-1:0]  d_stall_cnt_o;

   logic [31:0] mem_model [hcache_pkg::RAM_WORDS];
   bit          ic_valid [ICLINES];
   int          ic_tag [ICLINES];
   bit          dc_valid [DCLINES];
   int          dc_tag [DCLINES];
   int          i_misses; // Model miss counts, running from reset.
   int          d_misses;
   logic [31:0] lfsr_state;

   ram_harv_cache DUT (.*);

   initial wb_clk_i = 1'b0;
   always #(PERIOD/2) wb_clk_i = ~wb_clk_i;

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         r = {r[30:0], lfsr_state[0]};
      end
      return r;
   endfunction

   function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0] sel);
      logic [31:0] r;
      r = old_w;
      for (int b = 0; b < 4; b++)
         if (sel[b])
            r[8*b +: 8] = new_w[8*b +: 8];
      return r;
   endfunction

   task automatic check_val(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
      if (actual !== expected) begin
         $display("Error: %s expected %h actual %h", name, expected, actual);
         $display("test failed");
         $fatal(1);
      end
   endtask

   // All bus tasks start and end 1 ns after a rising edge.
   task automatic loader_write(input int word, input logic [31:0] dat, input logic [3:0] sel);
      int waits;
      waits = 0;
      ram_loader_adr_i = AW'(word * 4);
      ram_loader_dat_i = dat;
      ram_loader_sel_i = sel;
      ram_loader_we_i  = 1'b1;
      ram_loader_stb_i = 1'b1;
      @(negedge wb_clk_i);
      while (!ram_loader_ack_o) begin
         waits++;
         @(negedge wb_clk_i);
      end
      check_val("loader", 0, waits); // Loader writes never wait.
      @(posedge wb_clk_i);
      #1;
      ram_loader_stb_i = 1'b0;
      ram_loader_we_i  = 1'b0;
      mem_model[word] = merge_bytes(mem_model[word], dat, sel);
   endtask

   task automatic ibus_read(input int word, output logic [31:0] data, output int waits);
      waits = 0;
      iwb_adr_i = AW'(word * 4);
      iwb_stb_i = 1'b1;
      @(negedge wb_clk_i);
      while (!iwb_ack_o) begin
         waits++;
         @(negedge wb_clk_i);
      end
      data = iwb_dat_o; // Sampled mid-cycle.
      @(posedge wb_clk_i);
      #1;
      iwb_stb_i = 1'b0;
   endtask

   task automatic dbus_access(input int word, input logic we, input logic [31:0] wdat,
                              input logic [3:0] sel, output logic [31:0] rdat,
                              output int waits);
      waits = 0;
      dwb_adr_i = AW'(word * 4);
      dwb_dat_i = wdat;
      dwb_we_i  = we;
      dwb_sel_i = sel;
      dwb_stb_i = 1'b1;
      @(negedge wb_clk_i);
      while (!dwb_ack_o) begin
         waits++;
         @(negedge wb_clk_i);
      end
      rdat = dwb_dat_o;
      @(posedge wb_clk_i);
      #1;
      dwb_stb_i = 1'b0;
      dwb_we_i  = 1'b0;
   endtask

   task automatic fetch_word(input string name, input int word);
      int          idx;
      int          tag;
      int          waits;
      logic        miss;
      logic [31:0] got;
      idx  = word % ICLINES;
      tag  = word / ICLINES;
      miss = !(ic_valid[idx] && (ic_tag[idx] == tag));
      ibus_read(word, got, waits);
      check_val(name, mem_model[word], got);
      check_val(name, 32'(miss), waits); // One wait per miss.
      if (miss) begin
         ic_valid[idx] = 1'b1;
         ic_tag[idx]   = tag;
         i_misses++;
      end
   endtask

   task automatic read_data_word(input string name, input int word);
      int          idx;
      int          tag;
      int          waits;
      logic        miss;
      logic [31:0] got;
      idx  = word % DCLINES;
      tag  = word / DCLINES;
      miss = !(dc_valid[idx] && (dc_tag[idx] == tag));
      dbus_access(word, 1'b0, '0, 4'hF, got, waits);
      check_val(name, mem_model[word], got);
      check_val(name, 32'(miss), waits);
      if (miss) begin
         dc_valid[idx] = 1'b1;
         dc_tag[idx]   = tag;
         d_misses++;
      end
   endtask

   // Write-through keeps a cached line equal to memory.
   task automatic write_data_word(input string name, input int word, input logic [31:0] dat,
                                  input logic [3:0] sel);
      int          waits;
      logic [31:0] unused;
      dbus_access(word, 1'b1, dat, sel, unused, waits);
      check_val(name, 0, waits);
      mem_model[word] = merge_bytes(mem_model[word], dat, sel);
   endtask

   task automatic check_reset_state();
      @(negedge wb_clk_i);
      check_val("reset", 0, 32'(iwb_ack_o));
      check_val("reset", 0, 32'(dwb_ack_o));
      check_val("reset", 0, 32'(i_stall_cnt_o));
      check_val("reset", 0, 32'(d_stall_cnt_o));
      @(posedge wb_clk_i);
      #1;
   endtask

   task automatic load_and_fetch();
      int         w;
      logic [3:0] sel;
      for (int i = 0; i < N_LOAD; i++)
         loader_write(i, rand_bits(32), 4'hF);
      for (int i = 0; i < N_PART; i++) begin
         w   = int'(rand_bits(8));
         sel = 4'(rand_bits(4));
         loader_write(w, rand_bits(32), sel);
      end
      ram_loader_done_i = 1'b1; // Port 1 goes to the icache.
      for (int i = 0; i < N_FETCH; i++)
         fetch_word("load_fetch", i);
      check_val("load_fetch", 32'(i_misses), 32'(i_stall_cnt_o));
   endtask

   task automatic fetch_hits_misses();
      int w;
      // Words 0..7 and 64..71 fight over the same eight lines.
      for (int i = 0; i < N_MIX; i++) begin
         w = int'(rand_bits(3)) + ICLINES * int'(rand_bits(1));
         fetch_word("fetch_mix", w);
      end
      check_val("fetch_mix", 32'(i_misses), 32'(i_stall_cnt_o));
   endtask

   task automatic data_write_merge();
      int words [N_DWR];
      for (int i = 0; i < N_DPRE; i++)
         read_data_word("data_write", 128 + int'(rand_bits(7)));
      for (int i = 0; i < N_DWR; i++) begin
         words[i] = 128 + int'(rand_bits(7));
         write_data_word("data_write", words[i], rand_bits(32), 4'(rand_bits(4)));
      end
      for (int i = 0; i < N_DWR; i++)
         read_data_word("data_write", words[i]);
      check_val("data_write", 32'(d_misses), 32'(d_stall_cnt_o));
   endtask

   task automatic data_conflict_evict();
      for (int i = 0; i < N_EVICT; i++)
         read_data_word("evict", (i % 2 == 0) ? EVICT_A : EVICT_B);
      check_val("evict", 32'(d_misses), 32'(d_stall_cnt_o));
      write_data_word("evict", NEW_WORD, rand_bits(32), 4'hF);
      fetch_word("evict", NEW_WORD);
   endtask

   initial begin
      #(TIMEOUT);
      $display("Timeout, the DUT stopped answering before the tests were done.");
      $display("test failed");
      $fatal(1);
   end

   initial begin
      arst_n_i          = 1'b0;
      ram_loader_adr_i  = '0;
      ram_loader_dat_i  = '0;
      ram_loader_sel_i  = '0;
      ram_loader_we_i   = 1'b0;
      ram_loader_stb_i  = 1'b0;
      ram_loader_done_i = 1'b0;
      iwb_adr_i         = '0;
      iwb_stb_i         = 1'b0;
      dwb_adr_i         = '0;
      dwb_dat_i         = '0;
      dwb_we_i          = 1'b0;
      dwb_sel_i         = '0;
      dwb_stb_i         = 1'b0;
      lfsr_state        = 32'(SEED);
      i_misses          = 0;
      d_misses          = 0;
      for (int i = 0; i < ICLINES; i++)
         ic_valid[i] = 1'b0;
      for (int i = 0; i < DCLINES; i++)
         dc_valid[i] = 1'b0;
      repeat (RST_CYCLES) @(posedge wb_clk_i);
      #1;
      arst_n_i = 1'b1;

      check_reset_state();
      load_and_fetch();
      fetch_hits_misses();
      data_write_merge();
      data_conflict_evict();

      $display("test passed");
      $finish;
   end

endmodule

// File: ram_harv_cache.f
hcache_pkg.sv
dpram32.sv
icache.sv
dcache.sv
perf_stall_counter.sv
ram_harv_cache.sv
ram_harv_cache_checker.sv
tb_ram_harv_cache.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the Harvard cache testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module tb_ram_harv_cache \
   -f ram_harv_cache.f \
   -o sim_tb > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -q "test failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "test passed" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation PASSED"
